// File: activationStore.sv
`timescale 1ns/1ps

module activationStore
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic [numNodes*dataWidth-1:0] nodeOut,
	input logic [numNodes-1:0] nodeValid,
	output logic [numNodes*dataWidth-1:0] results,
	output logic busy,
	output logic done
);

	logic allValid;

	// Nodes share one start, so their valids line up.
	assign allValid = &nodeValid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			results <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			done <= 1'b0;
		end
		else if (allValid)
		begin
			results <= nodeOut;
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		|nodeValid |-> allValid);

	// Start is gated by busy upstream, so valid only lands in a busy window.
	assert property (@(posedge clk) disable iff (reset)
		|nodeValid |-> busy);

endmodule

// File: axiLiteSlave.sv
`timescale 1ns/1ps

module axiLiteSlave
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [numInputs*dataWidth-1:0] activations,
	output logic start,
	input logic [numNodes*dataWidth-1:0] results,
	input logic busy,
	input logic done
);

	logic [dataWidth-1:0] actRegs [numInputs];

	logic [addrWidth-1:0] wrOffset;
	logic [addrWidth-1:0] rdActOffset;
	logic [addrWidth-1:0] rdResOffset;
	logic [$clog2(numInputs)-1:0] wrIndex;
	logic [$clog2(numInputs)-1:0] rdActIndex;
	logic [$clog2(numNodes)-1:0] rdResIndex;
	logic wrIsAct;
	logic wrIsCtrl;
	logic rdIsAct;
	logic rdIsResult;
	logic writeFire;
	logic readFire;
	logic [1:0] writeResp;
	logic [1:0] readResp;
	logic [31:0] readData;

	// Address and data are taken in the same cycle.
	assign wready = awready;
	assign writeFire = awready && awvalid && wvalid;
	assign readFire = arready && arvalid;

	assign wrOffset = awaddr - actBase;
	assign wrIndex = wrOffset[2 +: $clog2(numInputs)];
	assign wrIsAct = (wrOffset[1:0] == 2'b00) && (wrOffset < addrWidth'(4 * numInputs));
	assign wrIsCtrl = (awaddr == ctrlAddr);
	assign writeResp = (wrIsAct || wrIsCtrl) ? respOkay : respSlverr;

	// A start while busy is dropped but still answers OKAY.
	assign start = writeFire && wrIsCtrl && wstrb[0] && wdata[0] && !busy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awready <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			awready <= awvalid && wvalid && !bvalid && !awready;
			if (writeFire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (writeFire)
			bresp <= writeResp;
	end

	// Byte lanes 0 and 1 only, the upper half is not stored.
	always_ff @(posedge clk)
	begin
		if (writeFire && wrIsAct)
		begin
			if (wstrb[0])
				actRegs[wrIndex][7:0] <= wdata[7:0];
			if (wstrb[1])
				actRegs[wrIndex][15:8] <= wdata[15:8];
		end
	end

	always_comb
	begin
		for (int i = 0; i < numInputs; i++)
			activations[i*dataWidth +: dataWidth] = actRegs[i];
	end

	assign rdActOffset = araddr - actBase;
	assign rdResOffset = araddr - resultBase;
	assign rdActIndex = rdActOffset[2 +: $clog2(numInputs)];
	assign rdResIndex = rdResOffset[2 +: $clog2(numNodes)];
	assign rdIsAct = (rdActOffset[1:0] == 2'b00) && (rdActOffset < addrWidth'(4 * numInputs));
	assign rdIsResult = (rdResOffset[1:0] == 2'b00) && (rdResOffset < addrWidth'(4 * numNodes));

	always_comb
	begin
		readData = '0;
		readResp = respOkay;
		if (rdIsAct)
			readData[dataWidth-1:0] = actRegs[rdActIndex];
		else if (rdIsResult)
			readData[dataWidth-1:0] = results[rdResIndex*dataWidth +: dataWidth];
		else if (araddr == statusAddr)
			readData[1:0] = {done, busy};
		else if (araddr != ctrlAddr)
			readResp = respSlverr;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !rvalid && !arready;
			if (readFire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (readFire)
		begin
			rdata <= readData;
			rresp <= readResp;
		end
	end

	// Responses hold with stable payload until taken.
	assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp));
	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// File: neuronNode.sv
`timescale 1ns/1ps

module neuronNode
	import nnPkg::*;
#(
	parameter int nodeIndex = 0
)
(
	input logic clk,
	input logic reset,
	input logic [numInputs*dataWidth-1:0] activations,
	input logic start,
	output logic [dataWidth-1:0] nodeOut,
	output logic nodeValid
);

	logic signed [dataWidth-1:0] weights [numInputs];
	logic signed [dataWidth-1:0] bias;
	logic signed [dataWidth-1:0] actReg [numInputs];
	logic signed [2*dataWidth-1:0] products [numInputs];
	logic signed [accWidth-1:0] sum;
	logic signed [accWidth-1:0] scaled;
	logic [dataWidth-1:0] clipped;
	logic inValid;
	logic prodValid;

	// Sign-magnitude to two's complement.
	function automatic logic signed [dataWidth-1:0] decodeWeight(input weightWord word);
		logic signed [dataWidth-1:0] magnitude;
		magnitude = $signed({1'b0, word.sm.magnitude});
		return word.sm.sign ? -magnitude : magnitude;
	endfunction

	always_comb
	begin
		for (int i = 0; i < numInputs; i++)
			weights[i] = decodeWeight(weightTable[nodeIndex][i]);
	end

	assign bias = decodeWeight(biasTable[nodeIndex]);

	// Stage 1.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < numInputs; i++)
			actReg[i] <= $signed(activations[i*dataWidth +: dataWidth]);
	end

	// Stage 2, full 32-bit products.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < numInputs; i++)
			products[i] <= actReg[i] * weights[i];
	end

	// Bias aligned to the Q14.16 product scale.
	always_comb
	begin
		sum = accWidth'(bias) <<< fracBits;
		for (int i = 0; i < numInputs; i++)
			sum = sum + products[i];
		scaled = sum >>> fracBits;
	end

	// ReLU, then saturate to the largest positive Q7.8.
	always_comb
	begin
		if (scaled[accWidth-1])
			clipped = '0;
		else if (|scaled[accWidth-2:dataWidth-1])
			clipped = {1'b0, {(dataWidth-1){1'b1}}};
		else
			clipped = scaled[dataWidth-1:0];
	end

	// Stage 3.
	always_ff @(posedge clk)
	begin
		nodeOut <= clipped;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inValid <= 1'b0;
			prodValid <= 1'b0;
			nodeValid <= 1'b0;
		end
		else
		begin
			inValid <= start;
			prodValid <= inValid;
			nodeValid <= prodValid;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		nodeValid == $past(start, 3));

endmodule

// File: nnAccelTop.sv
`timescale 1ns/1ps

module nnAccelTop
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	logic [numInputs*dataWidth-1:0] activations;
	logic start;
	logic [numNodes*dataWidth-1:0] nodeOut;
	logic [numNodes-1:0] nodeValid;
	logic [numNodes*dataWidth-1:0] results;
	logic busy;
	logic done;

	axiLiteSlave axiLiteSlave_inst (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.activations(activations),
		.start(start),
		.results(results),
		.busy(busy),
		.done(done)
	);

	for (genvar n = 0; n < numNodes; n++)
	begin : node
		neuronNode #(
			.nodeIndex(n)
		) neuronNode_inst (
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.start(start),
			.nodeOut(nodeOut[n*dataWidth +: dataWidth]),
			.nodeValid(nodeValid[n])
		);
	end

	activationStore activationStore_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.nodeOut(nodeOut),
		.nodeValid(nodeValid),
		.results(results),
		.busy(busy),
		.done(done)
	);

endmodule

// File: nnPkg.sv
package nnPkg;

	// Layer geometry.
	localparam int numInputs = 15;
	localparam int numNodes = 4;

	// Q7.8 activations and outputs.
	localparam int dataWidth = 16;
	localparam int fracBits = 8;

	// Wide enough for 15 full products plus the aligned bias.
	localparam int accWidth = 38;

	// Register map, byte addresses.
	localparam int addrWidth = 8;
	localparam logic [addrWidth-1:0] actBase = 8'h00;
	localparam logic [addrWidth-1:0] ctrlAddr = 8'h40;
	localparam logic [addrWidth-1:0] statusAddr = 8'h44;
	localparam logic [addrWidth-1:0] resultBase = 8'h80;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlverr = 2'b10;

	// Sign bit over a 15-bit magnitude.
	typedef struct packed {
		logic sign;
		logic [dataWidth-2:0] magnitude;
	} signMagnitude;

	typedef union packed {
		logic [dataWidth-1:0] raw;
		signMagnitude sm;
	} weightWord;

	// Sign-magnitude Q7.8, one row per node.
	localparam weightWord weightTable [numNodes][numInputs] = '{
		'{
			16'h804D, 16'h018A, 16'h0133, 16'h00BA, 16'h03A2,
			16'h0092, 16'h015E, 16'h0226, 16'h815C, 16'h0276,
			16'h81AF, 16'h80F1, 16'h8062, 16'h8024, 16'h00C7
		},
		'{
			16'h0110, 16'h80A4, 16'h0057, 16'h81C2, 16'h0238,
			16'h8019, 16'h00E6, 16'h0301, 16'h8097, 16'h0045,
			16'h812B, 16'h0188, 16'h80D3, 16'h0260, 16'h8071
		},
		'{
			16'h8205, 16'h00F3, 16'h8132, 16'h0089, 16'h80B8,
			16'h027C, 16'h0014, 16'h8166, 16'h01D9, 16'h8043,
			16'h00A1, 16'h8310, 16'h0127, 16'h80EE, 16'h019B
		},
		'{
			16'h00C4, 16'h0169, 16'h8036, 16'h8210, 16'h00FA,
			16'h803C, 16'h02B1, 16'h80E9, 16'h0075, 16'h014D,
			16'h8288, 16'h0021, 16'h81A6, 16'h00D8, 16'h8113
		}
	};

	localparam weightWord biasTable [numNodes] = '{
		16'h800A, 16'h0040, 16'h8080, 16'h0100
	};

endpackage

// File: run.sh
#!/bin/bash
set -o pipefail

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tbNnAccel -o simNnAccel \
	&& ./obj_dir/simNnAccel | tee sim.log \
	|| echo "Build or simulation ended with an error"

if [ -f sim.log ] && grep -qx "Finished with no errors" sim.log; then
	echo "PASS" && exit 0
fi
echo "FAIL"
exit 1

// File: src.f
nnPkg.sv
axiLiteSlave.sv
neuronNode.sv
activationStore.sv
nnAccelTop.sv
tbNnAccel.sv

// File: tbNnAccel.sv
`timescale 1ns/1ps

module tbNnAccel
	import nnPkg::*;
;

	typedef enum {opWrite, opRead, opLoad, opRun, opCheck, opDouble, opRandom} opKind;

	typedef struct {
		opKind op;
		logic [addrWidth-1:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [31:0] expData;
		logic [1:0] expResp;
	} tableEntry;

	logic clk;
	logic reset;
	logic [addrWidth-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [addrWidth-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int seed;
	int errorCount;
	int watchdogCycles;
	tableEntry steps [$];
	logic [dataWidth-1:0] shadowAct [numInputs];
	logic [dataWidth-1:0] runAct [numInputs];

	// Fixed test vectors, Q7.8.
	logic [dataWidth-1:0] vectors [2][numInputs] = '{
		'{16'h0100, 16'h0080, 16'hFF00, 16'h0200, 16'h0040, 16'hFFC0, 16'h0180, 16'h0000,
			16'hFE80, 16'h0100, 16'h0020, 16'hFF80, 16'h00C0, 16'h0300, 16'hFFE0},
		'{16'h0A00, 16'hF800, 16'h0333, 16'h1000, 16'hFCCD, 16'h0080, 16'h0700, 16'hF000,
			16'h0010, 16'h0555, 16'h0400, 16'hFF00, 16'h0999, 16'hF333, 16'h0001}
	};

	nnAccelTop nnAccelTop_inst (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	always #10 clk = ~clk;

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic checkTrue(logic cond, string what);
		assert (cond === 1'b1)
		else
		begin
			errorCount++;
			$display("Error: %s", what);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	function automatic int decodeSignMag(logic [dataWidth-1:0] raw);
		int magnitude;
		magnitude = int'(raw[dataWidth-2:0]);
		return raw[dataWidth-1] ? -magnitude : magnitude;
	endfunction

	function automatic int toInt(logic [dataWidth-1:0] value);
		return {{(32-dataWidth){value[dataWidth-1]}}, value};
	endfunction

	// Wide sum, rescale, then ReLU and saturation.
	function automatic logic [dataWidth-1:0] expectedOut(int n);
		longint acc;
		acc = longint'(decodeSignMag(biasTable[n].raw)) <<< fracBits;
		for (int i = 0; i < numInputs; i++)
			acc += longint'(toInt(runAct[i])) * longint'(decodeSignMag(weightTable[n][i].raw));
		acc = acc >>> fracBits;
		if (acc < 0)
			return 16'h0000;
		else if (acc > 32767)
			return 16'h7FFF;
		else
			return acc[dataWidth-1:0];
	endfunction

	task automatic busWrite(logic [addrWidth-1:0] addr, logic [31:0] data, logic [3:0] strb,
		logic [1:0] expResp, logic stallOn);
		int stall;
		int idx;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do
		begin
			@(posedge clk);
			#1;
			checkTrue(wready === awready, "awready and wready were not raised together");
		end
		while (!awready);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		stall = stallOn ? ($random(seed) & 3) : 0;
		repeat (stall)
		begin
			checkTrue(bvalid, "write response went away while bready was low");
			@(posedge clk);
			#1;
		end
		checkTrue(bvalid, "no write response arrived");
		checkValue("bresp", 32'(expResp), 32'(bresp));
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
		checkTrue(!bvalid, "write response was given more than once");
		if ((addr[1:0] == 2'b00) && (addr - actBase < 8'(4 * numInputs)))
		begin
			idx = int'(addr - actBase) / 4;
			if (strb[0])
				shadowAct[idx][7:0] = data[7:0];
			if (strb[1])
				shadowAct[idx][15:8] = data[15:8];
		end
	endtask

	task automatic busRead(logic [addrWidth-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp, input logic stallOn);
		int stall;
		araddr = addr;
		arvalid = 1'b1;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!arready);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		stall = stallOn ? ($random(seed) & 3) : 0;
		repeat (stall)
		begin
			checkTrue(rvalid, "read response went away while rready was low");
			@(posedge clk);
			#1;
		end
		checkTrue(rvalid, "no read response arrived");
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
		checkTrue(!rvalid, "read response was given more than once");
	endtask

	// Kinds 0 and 1 from the vector table, 2 and 3 push node 0 out of range, 4 is random.
	task automatic loadVector(int kind);
		logic [31:0] r;
		logic [dataWidth-1:0] act;
		for (int i = 0; i < numInputs; i++)
		begin
			r = $random(seed);
			case (kind)
				0, 1: act = vectors[kind][i];
				2: act = weightTable[0][i].raw[dataWidth-1] ? 16'h8000 : 16'h7FFF;
				3: act = weightTable[0][i].raw[dataWidth-1] ? 16'h7FFF : 16'h8000;
				default: act = r[dataWidth-1:0];
			endcase
			busWrite(actBase + 8'(4 * i), {16'h0000, act}, 4'b0011, respOkay, 1'b1);
		end
	endtask

	task automatic checkResults();
		logic [31:0] data;
		logic [1:0] resp;
		for (int n = 0; n < numNodes; n++)
		begin
			busRead(resultBase + 8'(4 * n), data, resp, 1'b1);
			checkValue($sformatf("rdata result%0d", n), {16'h0000, expectedOut(n)}, data);
			checkValue("rresp", 32'(respOkay), 32'(resp));
		end
	endtask

	task automatic runInference();
		logic [31:0] data;
		logic [1:0] resp;
		busWrite(ctrlAddr, 32'h1, 4'b0001, respOkay, 1'b1);
		runAct = shadowAct;
		do
		begin
			busRead(statusAddr, data, resp, 1'b1);
			checkValue("rresp", 32'(respOkay), 32'(resp));
		end
		while (!data[1]);
		checkValue("rdata status", 32'h2, data);
		checkResults();
	endtask

	// Without stalls the second start fires on the capture cycle, still busy.
	task automatic startTwice();
		logic [31:0] data;
		logic [1:0] resp;
		busWrite(ctrlAddr, 32'h1, 4'b0001, respOkay, 1'b0);
		runAct = shadowAct;
		busWrite(ctrlAddr, 32'h1, 4'b0001, respOkay, 1'b0);
		busRead(statusAddr, data, resp, 1'b0);
		checkValue("rdata status", 32'h2, data);
	endtask

	task automatic addStep(opKind op, logic [addrWidth-1:0] addr, logic [31:0] data,
		logic [3:0] strb, logic [31:0] expData, logic [1:0] expResp);
		tableEntry s;
		s = '{op, addr, data, strb, expData, expResp};
		steps.push_back(s);
	endtask

	// Forty cycles per bus transaction.
	function automatic int stepCycles(tableEntry s);
		case (s.op)
			opLoad: return 15 * 40;
			opRun: return 10 * 40;
			opCheck: return 4 * 40;
			opDouble: return 3 * 40;
			opRandom: return int'(s.data) * 25 * 40;
			default: return 40;
		endcase
	endfunction

	task automatic runStep(tableEntry s);
		logic [31:0] data;
		logic [1:0] resp;
		case (s.op)
			opWrite: busWrite(s.addr, s.data, s.strb, s.expResp, 1'b1);
			opRead:
			begin
				busRead(s.addr, data, resp, 1'b1);
				checkValue("rdata", s.expData, data);
				checkValue("rresp", 32'(s.expResp), 32'(resp));
			end
			opLoad: loadVector(int'(s.data));
			opRun: runInference();
			opCheck: checkResults();
			opDouble: startTwice();
			default:
			begin
				repeat (s.data)
				begin
					loadVector(4);
					runInference();
				end
			end
		endcase
	endtask

	initial
	begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge clk);
		$display("Timeout: the test did not finish within %0d cycles", watchdogCycles);
		$display("Finished with errors");
		$fatal(1);
	end

	initial
	begin
		int total;
		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		seed = 16184;
		errorCount = 0;
		for (int i = 0; i < numInputs; i++)
			shadowAct[i] = '0;

		addStep(opRead, statusAddr, 0, 0, 32'h0, respOkay);
		addStep(opWrite, 8'h0C, 32'h1234, 4'b0011, 0, respOkay);
		addStep(opRead, 8'h0C, 0, 0, 32'h1234, respOkay);
		addStep(opWrite, 8'h0C, 32'h00AB, 4'b0001, 0, respOkay);
		addStep(opRead, 8'h0C, 0, 0, 32'h12AB, respOkay);
		addStep(opWrite, 8'h0C, 32'hCD00, 4'b0010, 0, respOkay);
		addStep(opRead, 8'h0C, 0, 0, 32'hCDAB, respOkay);
		addStep(opWrite, 8'h38, 32'hFFFF8001, 4'b1111, 0, respOkay);
		addStep(opRead, 8'h38, 0, 0, 32'h8001, respOkay);
		addStep(opLoad, 0, 0, 0, 0, respOkay);
		addStep(opRun, 0, 0, 0, 0, respOkay);
		addStep(opWrite, resultBase, 32'hFFFF, 4'b0011, 0, respSlverr);
		addStep(opWrite, statusAddr, 32'h3, 4'b0001, 0, respSlverr);
		addStep(opCheck, 0, 0, 0, 0, respOkay);
		addStep(opRead, statusAddr, 0, 0, 32'h2, respOkay);
		addStep(opRead, 8'h48, 0, 0, 32'h0, respSlverr);
		addStep(opRead, 8'h90, 0, 0, 32'h0, respSlverr);
		addStep(opRead, 8'h02, 0, 0, 32'h0, respSlverr);
		addStep(opWrite, 8'h3C, 32'h5555, 4'b0011, 0, respSlverr);
		addStep(opLoad, 0, 1, 0, 0, respOkay);
		addStep(opRun, 0, 0, 0, 0, respOkay);
		addStep(opLoad, 0, 2, 0, 0, respOkay);
		addStep(opRun, 0, 0, 0, 0, respOkay);
		addStep(opRead, resultBase, 0, 0, 32'h7FFF, respOkay);
		addStep(opLoad, 0, 3, 0, 0, respOkay);
		addStep(opRun, 0, 0, 0, 0, respOkay);
		addStep(opRead, resultBase, 0, 0, 32'h0, respOkay);
		addStep(opLoad, 0, 0, 0, 0, respOkay);
		addStep(opDouble, 0, 0, 0, 0, respOkay);
		addStep(opWrite, actBase, 32'h7FFF, 4'b0011, 0, respOkay);
		addStep(opCheck, 0, 0, 0, 0, respOkay);
		addStep(opRandom, 0, 20, 0, 0, respOkay);

		total = 5 + 40;
		foreach (steps[k])
			total += stepCycles(steps[k]);
		watchdogCycles = total;

		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		foreach (steps[k])
			runStep(steps[k]);

		if (errorCount == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
		begin
			$display("Finished with errors");
			$fatal(1);
		end
	end

endmodule
